// File: build.f
+incdir+src
src/meter_pkg.sv
src/display_pkg.sv
src/gate_counter.sv
src/bin_to_bcd.sv
src/display_scan.sv
src/frequency_meter.sv
tests/frequency_meter_checker.sv
tests/frequency_meter_monitor.sv
tests/frequency_meter_tb.sv

// File: src/bin_to_bcd.sv
// Sequential binary to BCD converter (shift and add 3).
// A count_valid strobe starts one conversion of FM_COUNT_WIDTH shifts;
// bcd_valid pulses FM_COUNT_WIDTH+1 clocks after the start strobe.

`timescale 1ns/100ps
`include "freq_meter_config.svh"

module bin_to_bcd (
	input  logic              clock,
	input  logic              reset,
	input  meter_pkg::count_t count,
	input  logic              count_valid,
	output meter_pkg::bcd_t   bcd,
	output logic              bcd_valid
);

	localparam int step_width = $clog2(`FM_COUNT_WIDTH);
	localparam logic [step_width-1:0] last_step = step_width'(`FM_COUNT_WIDTH - 1);

	// conversion state
	logic                  busy;
	logic [step_width-1:0] step;
	logic                  start;
	logic                  last_shift;

	// binary bits still to shift in, MSB first
	meter_pkg::count_t bin_shift;

	// partial BCD result and its next value
	meter_pkg::bcd_t bcd_work;
	meter_pkg::bcd_t bcd_adjusted;
	meter_pkg::bcd_t bcd_next;

	// ignored while busy, the gate is far longer than a conversion
	assign start      = count_valid & ~busy;
	assign last_shift = busy && (step == last_step);

	// add 3 to every nibble of 5 or more before the shift
	always_comb begin
		bcd_adjusted = bcd_work;
		for (int i = 0; i < `FM_DIGITS; i++) begin
			if (bcd_work[4*i +: 4] >= 4'd5) begin
				bcd_adjusted[4*i +: 4] = bcd_work[4*i +: 4] + 4'd3;
			end
		end
	end

	// shift left by one, next binary bit enters at the bottom
	assign bcd_next = {bcd_adjusted[$bits(meter_pkg::bcd_t)-2:0], bin_shift[`FM_COUNT_WIDTH-1]};

	// sequencing
	always_ff @(posedge clock) begin
		if (reset) begin
			busy      <= 1'b0;
			step      <= '0;
			bcd_valid <= 1'b0;
		end else begin
			bcd_valid <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (last_shift) begin
					busy      <= 1'b0;
					bcd_valid <= 1'b1;
				end
			end
		end
	end

	// shift registers and result word
	always_ff @(posedge clock) begin
		if (start) begin
			bin_shift <= count;
			bcd_work  <= '0;
		end else if (busy) begin
			bin_shift <= bin_shift << 1;
			bcd_work  <= bcd_next;
		end
		// publish on the final shift, alongside bcd_valid
		if (last_shift) begin
			bcd <= bcd_next;
		end
	end

endmodule

// File: src/display_pkg.sv
// Display word types and the seven-segment decode.
// Segment bits are active high, ordered g,f,e,d,c,b,a,dp from MSB.
// decode_digit is used by the scan logic and by the monitor.

`include "freq_meter_config.svh"

package display_pkg;

	// one BCD digit
	typedef logic [3:0] digit_t;

	// segments g..a then dp in bit 0
	typedef logic [7:0] segment_t;

	// one-hot digit select
	typedef logic [`FM_DIGITS-1:0] anode_t;

	// BCD digit to segment pattern, dp always off
	function automatic segment_t decode_digit(input digit_t digit);
		segment_t pattern;
		case (digit)
			4'd0: pattern = 8'b0111_1110;
			4'd1: pattern = 8'b0000_1100;
			4'd2: pattern = 8'b1011_0110;
			4'd3: pattern = 8'b1001_1110;
			4'd4: pattern = 8'b1100_1100;
			4'd5: pattern = 8'b1101_1010;
			4'd6: pattern = 8'b1111_1010;
			4'd7: pattern = 8'b0000_1110;
			4'd8: pattern = 8'b1111_1110;
			4'd9: pattern = 8'b1101_1110;
			// not a BCD digit, show a dash on segment g
			default: pattern = 8'b1000_0000;
		endcase
		return pattern;
	endfunction

endpackage

// File: src/display_scan.sv
// Multiplexed drive for the eight-digit seven-segment display.
// Latches each new BCD result and lights one digit at a time,
// blanking leading zeros above the decimal point digit.

`timescale 1ns/100ps
`include "freq_meter_config.svh"

module display_scan (
	input  logic                  clock,
	input  logic                  reset,
	input  meter_pkg::bcd_t       bcd,
	input  logic                  bcd_valid,
	output display_pkg::segment_t segment,
	output display_pkg::anode_t   anode
);

	localparam int scan_width  = $clog2(`FM_SCAN_CYCLES);
	localparam int index_width = $clog2(`FM_DIGITS);
	localparam logic [scan_width-1:0]  last_scan  = scan_width'(`FM_SCAN_CYCLES - 1);
	localparam logic [index_width-1:0] last_digit = index_width'(`FM_DIGITS - 1);
	localparam logic [index_width-1:0] dp_index   = index_width'(`FM_DP_DIGIT);

	// displayed value, and whether one has arrived yet
	meter_pkg::bcd_t held_bcd;
	logic            loaded;

	// scan position
	logic [scan_width-1:0]  scan_timer;
	logic [index_width-1:0] digit_index;

	// per-digit blanking and the selected digit
	logic [`FM_DIGITS-1:0]  blank;
	display_pkg::digit_t    digit;
	display_pkg::segment_t  pattern;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_bcd <= '0;
			loaded   <= 1'b0;
		end else if (bcd_valid) begin
			held_bcd <= bcd;
			loaded   <= 1'b1;
		end
	end

	// digit advances every FM_SCAN_CYCLES clocks, 0 upward, wraps after the top
	always_ff @(posedge clock) begin
		if (reset) begin
			scan_timer  <= '0;
			digit_index <= '0;
		end else if (scan_timer == last_scan) begin
			scan_timer  <= '0;
			digit_index <= (digit_index == last_digit) ? '0 : digit_index + 1'b1;
		end else begin
			scan_timer <= scan_timer + 1'b1;
		end
	end

	assign anode = display_pkg::anode_t'(1) << digit_index;

	// walk down from the top digit
	// a digit blanks while it and all above it are zero,
	// never at or below the dp digit
	always_comb begin
		logic upper_zero;
		upper_zero = 1'b1;
		for (int i = `FM_DIGITS - 1; i >= 0; i--) begin
			upper_zero = upper_zero & (held_bcd[4*i +: 4] == 4'd0);
			blank[i]   = upper_zero && (i > `FM_DP_DIGIT);
		end
	end

	assign digit = held_bcd[4*digit_index +: 4];

	always_comb begin
		pattern = display_pkg::decode_digit(digit);
		// fixed decimal point
		if (digit_index == dp_index) begin
			pattern[0] = 1'b1;
		end
		if (blank[digit_index]) begin
			pattern = '0;
		end
	end

	// dark until the first result is latched
	assign segment = loaded ? pattern : '0;

endmodule

// File: src/freq_meter_config.svh
// Build-time constants for the frequency meter.
// Include this wherever a gate, scan or display size is needed.
// Override by editing the defaults below before compiling.

`ifndef FREQ_METER_CONFIG_SVH
`define FREQ_METER_CONFIG_SVH

// gate window length in clocks
// kept short so simulation runs fast
`define FM_GATE_CYCLES 2000

// clocks each display digit stays lit
`define FM_SCAN_CYCLES 8

// digits on the display, one BCD nibble each
`define FM_DIGITS 8

// digit whose decimal point is lit
`define FM_DP_DIGIT 2

// count width, enough for 99,999,999
`define FM_COUNT_WIDTH 27

`endif

// File: src/frequency_meter.sv
// Top level of the frequency meter.
// signal_in is counted per gate window, converted to BCD and scanned
// onto the display; the internal strobes are brought out for observation.

`timescale 1ns/100ps

module frequency_meter (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  signal_in,
	output meter_pkg::count_t     count,
	output logic                  count_valid,
	output meter_pkg::bcd_t       bcd,
	output logic                  bcd_valid,
	output display_pkg::segment_t segment,
	output display_pkg::anode_t   anode
);

	// edge count per gate window
	gate_counter u_gate (
		.clock       (clock),
		.reset       (reset),
		.signal_in   (signal_in),
		.count       (count),
		.count_valid (count_valid)
	);

	// count to BCD, finishes FM_COUNT_WIDTH+1 clocks after count_valid
	bin_to_bcd u_bcd (
		.clock       (clock),
		.reset       (reset),
		.count       (count),
		.count_valid (count_valid),
		.bcd         (bcd),
		.bcd_valid   (bcd_valid)
	);

	// digit multiplexing onto the common-anode display
	display_scan u_scan (
		.clock     (clock),
		.reset     (reset),
		.bcd       (bcd),
		.bcd_valid (bcd_valid),
		.segment   (segment),
		.anode     (anode)
	);

endmodule

// File: src/gate_counter.sv
// Input side of the frequency meter.
// Samples signal_in into the clock domain and counts its rising edges
// over fixed windows of FM_GATE_CYCLES clocks and reports one count per window.

`timescale 1ns/100ps
`include "freq_meter_config.svh"

module gate_counter (
	input  logic              clock,
	input  logic              reset,
	input  logic              signal_in,
	output meter_pkg::count_t count,
	output logic              count_valid
);

	localparam int timer_width = $clog2(`FM_GATE_CYCLES);
	localparam logic [timer_width-1:0] last_tick = timer_width'(`FM_GATE_CYCLES - 1);

	// synchronizer pair plus history flop for the edge detect
	logic sync_0;
	logic sync_1;
	logic sync_2;
	logic rise;

	logic                   window_end;
	logic [timer_width-1:0] gate_timer;
	meter_pkg::count_t      edge_count;

	// synchronizer chain tracks the input even while reset is high
	always_ff @(posedge clock) begin
		sync_0 <= signal_in;
		sync_1 <= sync_0;
		sync_2 <= sync_1;
	end

	// one-cycle pulse per rising edge that the next clock counts
	assign rise = sync_1 & ~sync_2;

	assign window_end = (gate_timer == last_tick);

	// window timer starts at 1 after reset
	// count_valid trails window_end by a clock and so lands in the window's last cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			gate_timer <= timer_width'(1);
		end else if (window_end) begin
			gate_timer <= '0;
		end else begin
			gate_timer <= gate_timer + 1'b1;
		end
	end

	// edge counter restarts at each window end
	// an edge seen on the closing clock belongs to the new window
	always_ff @(posedge clock) begin
		if (reset) begin
			edge_count  <= '0;
			count_valid <= 1'b0;
		end else begin
			count_valid <= window_end;
			if (window_end) begin
				edge_count <= meter_pkg::count_t'(rise);
			end else if (rise) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

	// result word held until the next window closes
	always_ff @(posedge clock) begin
		if (window_end) begin
			count <= edge_count;
		end
	end

endmodule

// File: src/meter_pkg.sv
// Measurement word types for the frequency meter.
// Shared by the gate counter, the BCD converter and the testbench.

`include "freq_meter_config.svh"

package meter_pkg;

	// total width of the packed BCD result
	localparam int bcd_width = 4 * `FM_DIGITS;

	// binary edge count from one gate window
	typedef logic [`FM_COUNT_WIDTH-1:0] count_t;

	// packed BCD digits
	// nibble 0 is the least significant digit
	typedef logic [bcd_width-1:0] bcd_t;

endpackage

// File: tests/frequency_meter_checker.sv
// Concurrent assertions on the frequency meter strobes and digit scan.
// Bound into frequency_meter from the testbench.

`timescale 1ns/100ps
`include "freq_meter_config.svh"

module frequency_meter_checker (
	input logic                clock,
	input logic                reset,
	input logic                count_valid,
	input logic                bcd_valid,
	input logic                converter_busy,
	input display_pkg::anode_t anode
);

	// strobes last exactly one cycle
	single_count_valid: assert property (@(posedge clock) disable iff (reset)
		count_valid |=> !count_valid) else $error("count_valid high two cycles in a row");
	single_bcd_valid: assert property (@(posedge clock) disable iff (reset)
		bcd_valid |=> !bcd_valid) else $error("bcd_valid high two cycles in a row");

	// no new count while a conversion runs
	start_when_idle: assert property (@(posedge clock) disable iff (reset)
		!(count_valid && converter_busy)) else $error("count_valid while converter busy");

	anode_one_hot: assert property (@(posedge clock) disable iff (reset)
		$onehot(anode)) else $error("anode not one-hot");

	// conversion latency, both directions
	bcd_after_count: assert property (@(posedge clock) disable iff (reset)
		count_valid |-> ##(`FM_COUNT_WIDTH + 1) bcd_valid) else $error("bcd_valid missing");
	bcd_has_count: assert property (@(posedge clock) disable iff (reset)
		bcd_valid |-> $past(count_valid, `FM_COUNT_WIDTH + 1)) else $error("stray bcd_valid");

endmodule

// File: tests/frequency_meter_monitor.sv
// Watches the frequency meter ports and compares them with reference values.
// Counts the driven input edges per gate window and models the digit scan.

`timescale 1ns/100ps
`include "freq_meter_config.svh"

module frequency_meter_monitor (
	input logic                  clock,
	input logic                  reset,
	input logic                  signal_in,
	input meter_pkg::count_t     count,
	input logic                  count_valid,
	input meter_pkg::bcd_t       bcd,
	input logic                  bcd_valid,
	input display_pkg::segment_t segment,
	input display_pkg::anode_t   anode
);

	// standard patterns for digits 9 down to 0, bits g,f,e,d,c,b,a,dp
	localparam logic [79:0] seg_table = {8'hde, 8'hfe, 8'h0e, 8'hfa, 8'hda,
		8'hcc, 8'h9e, 8'hb6, 8'h0c, 8'h7e};

	int error_count = 0;

	// driven input history, bit 0 is the value set on the latest edge
	logic [4:0]            input_hist = '0;
	logic                  landed;
	logic                  prev_reset = 1'b0;
	logic                  armed = 1'b0;
	int                    window_edges = 0;
	int                    since_count = -1;
	meter_pkg::count_t     last_count = '0;
	// display model
	logic                  prev_bcd_valid = 1'b0;
	meter_pkg::bcd_t       prev_bcd = '0;
	meter_pkg::bcd_t       held_bcd = '0;
	logic                  loaded = 1'b0;
	int                    scan_timer = 0;
	int                    scan_digit = 0;
	display_pkg::segment_t want_segment;

	// binary to packed BCD by repeated division
	function automatic meter_pkg::bcd_t ref_bcd(input meter_pkg::count_t value);
		meter_pkg::bcd_t word;
		int unsigned     rest;
		rest = value;
		for (int i = 0; i < `FM_DIGITS; i++) begin
			word[4*i +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return word;
	endfunction

	// blank leading zeros above the dp digit, dp lit on its own digit
	function automatic display_pkg::segment_t ref_segments(input int index,
			input meter_pkg::bcd_t word);
		display_pkg::segment_t pattern;
		logic [3:0]            digit;
		bit                    leading;
		digit   = word[4*index +: 4];
		leading = (index > `FM_DP_DIGIT);
		for (int i = index; i < `FM_DIGITS; i++) begin
			if (word[4*i +: 4] != 4'd0) begin
				leading = 1'b0;
			end
		end
		pattern = seg_table[8*digit +: 8];
		if (index == `FM_DP_DIGIT) begin
			pattern[0] = 1'b1;
		end
		return leading ? display_pkg::segment_t'(0) : pattern;
	endfunction

	task automatic flag_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		error_count++;
		$display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	// outputs are settled at the falling edge
	always @(negedge clock) begin
		input_hist = {input_hist[3:0], signal_in};
		// rise driven three edges back is counted on the latest edge
		landed = input_hist[3] & ~input_hist[4];
		if (prev_reset) begin
			armed        = 1'b1;
			window_edges = 0;
			since_count  = -1;
			held_bcd     = '0;
			loaded       = 1'b0;
			scan_timer   = 0;
			scan_digit   = 0;
			if (count_valid || bcd_valid) begin
				error_count++;
				$display("ERROR at %0t: a strobe is high during reset", $time);
			end
		end else if (armed) begin
			if (count_valid) begin
				if (count !== meter_pkg::count_t'(window_edges)) begin
					flag_mismatch("count", window_edges, count);
				end
				last_count   = count;
				since_count  = 0;
				// an edge landing on the closing clock opens the next window
				window_edges = landed;
			end else begin
				window_edges += landed;
				if (since_count >= 0) begin
					since_count++;
				end
			end
			if (bcd_valid) begin
				if (since_count != `FM_COUNT_WIDTH + 1) begin
					error_count++;
					$display("ERROR at %0t: bcd_valid came %0d cycles after count_valid",
						$time, since_count);
				end
				if (bcd !== ref_bcd(last_count)) begin
					flag_mismatch("bcd", ref_bcd(last_count), bcd);
				end
			end
			if (prev_bcd_valid) begin
				held_bcd = prev_bcd;
				loaded   = 1'b1;
			end
			scan_timer++;
			if (scan_timer == `FM_SCAN_CYCLES) begin
				scan_timer = 0;
				scan_digit = (scan_digit + 1) % `FM_DIGITS;
			end
		end
		if (armed) begin
			if (anode !== display_pkg::anode_t'(1 << scan_digit)) begin
				flag_mismatch("anode", 1 << scan_digit, anode);
			end
			want_segment = loaded ? ref_segments(scan_digit, held_bcd) : '0;
			if (segment !== want_segment) begin
				flag_mismatch("segment", want_segment, segment);
			end
		end
		prev_reset     = reset;
		prev_bcd_valid = bcd_valid;
		prev_bcd       = bcd;
	end

endmodule

// File: tests/frequency_meter_tb.sv
// Testbench for the frequency meter.
// Drives signal_in as square waves or random bits, runs one test per
// behavior and prints a line per test plus a closing summary.

`timescale 1ns/100ps
`include "freq_meter_config.svh"

module frequency_meter_tb;

	// bound for any single wait, in clocks
	localparam int wait_limit = 3 * `FM_GATE_CYCLES;

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  signal_in;
	meter_pkg::count_t     count;
	logic                  count_valid;
	meter_pkg::bcd_t       bcd;
	logic                  bcd_valid;
	display_pkg::segment_t segment;
	display_pkg::anode_t   anode;

	// input waveform, changed only between clock edges
	int          wave_period = 0;
	bit          random_input = 1'b0;
	int          phase = 0;
	integer      seed = 32'h9ff7;
	logic [31:0] random_word;

	int local_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_mark = 0;

	frequency_meter dut (.*);

	frequency_meter_monitor mon (.*);

	bind frequency_meter frequency_meter_checker u_check (
		.clock          (clock),
		.reset          (reset),
		.count_valid    (count_valid),
		.bcd_valid      (bcd_valid),
		.converter_busy (u_bcd.busy),
		.anode          (anode)
	);

	initial begin
		forever #5 clock = ~clock;
	end

	// square wave high for the first half of each period, or random bits
	always @(posedge clock) begin
		if (random_input) begin
			random_word = $random(seed);
			signal_in <= random_word[0];
		end else if (wave_period < 2) begin
			signal_in <= 1'b0;
		end else begin
			phase = (phase + 1) % wave_period;
			signal_in <= (phase < wave_period / 2);
		end
	end

	function automatic int total_errors();
		return local_errors + mon.error_count;
	endfunction

	task automatic note_mismatch(input string name, input int expected, input int actual);
		local_errors++;
		$display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
	endtask

	task automatic end_test(input string name);
		int found;
		found = total_errors() - test_mark;
		if (found == 0) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, found);
		end
		test_mark = total_errors();
	endtask

	// waits for count_valid, or bcd_valid when for_bcd is set
	task automatic wait_strobe(input bit for_bcd, input int limit, output int waited);
		bit seen;
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < limit) begin
			@(negedge clock);
			waited++;
			seen = for_bcd ? bcd_valid : count_valid;
		end
		if (!seen) begin
			local_errors++;
			$display("ERROR at %0t: timed out waiting for %s", $time,
				for_bcd ? "bcd_valid" : "count_valid");
		end
	endtask

	task automatic measure_square(input int period);
		int expected;
		int waited;
		wave_period = period;
		expected    = `FM_GATE_CYCLES / period;
		// first window straddles the period change
		wait_strobe(1'b0, wait_limit, waited);
		repeat (2) begin
			wait_strobe(1'b0, wait_limit, waited);
			if (waited != `FM_GATE_CYCLES) begin
				note_mismatch("count_valid spacing", `FM_GATE_CYCLES, waited);
			end
			if (int'(count) < expected - 1 || int'(count) > expected + 1) begin
				note_mismatch("count", expected, int'(count));
			end
		end
		end_test($sformatf("known frequency, period %0d", period));
	endtask

	task automatic check_conversion();
		int waited;
		wave_period = 10;
		wait_strobe(1'b0, wait_limit, waited);
		wait_strobe(1'b1, `FM_COUNT_WIDTH + 10, waited);
		if (waited != `FM_COUNT_WIDTH + 1) begin
			note_mismatch("bcd_valid delay", `FM_COUNT_WIDTH + 1, waited);
		end
		end_test("conversion");
	endtask

	// two results so the shown value comes from a full window
	task automatic show_value(input int period, input string name);
		int waited;
		wave_period = period;
		repeat (2) wait_strobe(1'b1, wait_limit, waited);
		repeat (2 * `FM_DIGITS * `FM_SCAN_CYCLES) @(negedge clock);
		end_test(name);
	endtask

	task automatic mid_run_reset();
		int waited;
		bit seen;
		wait_strobe(1'b0, wait_limit, waited);
		// hit the converter mid conversion
		repeat (5) @(negedge clock);
		@(posedge clock);
		reset <= 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < wait_limit) begin
			@(negedge clock);
			waited++;
			seen = count_valid;
			if (bcd_valid) begin
				note_mismatch("bcd_valid", 0, 1);
			end
			if (segment !== '0) begin
				note_mismatch("segment", 0, segment);
			end
		end
		if (!seen) begin
			local_errors++;
			$display("ERROR at %0t: timed out waiting for count_valid after reset", $time);
		end else if (waited != `FM_GATE_CYCLES) begin
			note_mismatch("first count_valid after reset", `FM_GATE_CYCLES, waited);
		end
		wait_strobe(1'b1, wait_limit, waited);
		end_test("mid-run reset");
	endtask

	initial begin
		int waited;
		reset     = 1'b1;
		signal_in = 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		measure_square(4);
		measure_square(10);
		measure_square(37);
		random_input = 1'b1;
		repeat (3) wait_strobe(1'b0, wait_limit, waited);
		random_input = 1'b0;
		end_test("exact edge count, random input");
		check_conversion();
		show_value(0, "display of zero");
		show_value(300, "display of one digit");
		// fastest input, the widest count one gate allows
		show_value(2, "display of four digits");
		repeat (3 * `FM_DIGITS * `FM_SCAN_CYCLES) @(negedge clock);
		end_test("scan order");
		mid_run_reset();
		$display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
